/* cpu_core.f */
+incdir+.
cpu_pkg.sv
cpu_controller.sv
cpu_regfile.sv
cpu_alu.sv
cpu_core.sv
cpu_core_sva.sv
tb_cpu_core.sv

/* tb_cpu_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module tb_cpu_core;
	import cpu_pkg::*;

	typedef struct packed {
		word_t instr;
		logic  exp_read;
		logic  exp_write;
		addr_t exp_addr;
		word_t exp_data;
	} row_t;

	logic  clock;
	logic  reset;
	logic  im_enable;
	addr_t im_addr;
	word_t im_rdata;
	logic  dm_read;
	logic  dm_write;
	addr_t dm_addr;
	word_t dm_wdata;
	word_t dm_rdata;

	row_t  prog [0:63];
	int    n_rows;
	word_t data_mem [0:127];

	cpu_core u_dut (
		.clock     (clock),
		.reset     (reset),
		.im_enable (im_enable),
		.im_addr   (im_addr),
		.im_rdata  (im_rdata),
		.dm_read   (dm_read),
		.dm_write  (dm_write),
		.dm_addr   (dm_addr),
		.dm_wdata  (dm_wdata),
		.dm_rdata  (dm_rdata)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic check_value(input word_t got, input word_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s, got %h, expected %h", $time, what, got, exp);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	function automatic word_t base_instr(input base_sub_t sub, input reg_idx_t rt,
			input reg_idx_t ra, input reg_idx_t rb);
		return {1'b0, TY_BASE, rt, ra, rb, 5'b00000, sub};
	endfunction

	function automatic word_t imm_instr(input opcode_t op, input reg_idx_t rt,
			input reg_idx_t ra, input logic [14:0] imm);
		return {1'b0, op, rt, ra, imm};
	endfunction

	function automatic word_t movi_instr(input reg_idx_t rt, input logic [19:0] imm);
		return {1'b0, MOVI, rt, imm};
	endfunction

	function automatic word_t ls_instr(input ls_sub_t sub, input reg_idx_t rt,
			input reg_idx_t ra, input reg_idx_t rb, input logic [1:0] sv);
		return {1'b0, TY_LS, rt, ra, rb, sv, sub};
	endfunction

	task automatic add_row(input word_t instr, input logic rd, input logic wr,
			input addr_t addr, input word_t data);
		prog[n_rows].instr     = instr;
		prog[n_rows].exp_read  = rd;
		prog[n_rows].exp_write = wr;
		prog[n_rows].exp_addr  = addr;
		prog[n_rows].exp_data  = data;
		n_rows++;
	endtask

	// r10 holds the store base 0x100
	task automatic load_program();
		add_row(movi_instr(1, 20'h12345), 0, 0, 0, 0);
		add_row(movi_instr(2, 20'hffffe), 0, 0, 0, 0);
		add_row(movi_instr(10, 20'h00100), 0, 0, 0, 0);
		add_row(imm_instr(SWI, 1, 10, 0), 0, 1, 32'h100, 32'h0001_2345);
		add_row(imm_instr(SWI, 2, 10, 1), 0, 1, 32'h104, 32'hffff_fffe);
		add_row(base_instr(ADD, 3, 1, 2), 0, 0, 0, 0);
		add_row(imm_instr(SWI, 3, 10, 2), 0, 1, 32'h108, 32'h0001_2343);
		add_row(base_instr(SUB, 4, 2, 1), 0, 0, 0, 0);
		add_row(imm_instr(SWI, 4, 10, 3), 0, 1, 32'h10c, 32'hfffe_dcb9);
		add_row(base_instr(SUB, 5, 1, 2), 0, 0, 0, 0);
		add_row(imm_instr(SWI, 5, 10, 4), 0, 1, 32'h110, 32'h0001_2347);
		add_row(base_instr(AND, 6, 1, 2), 0, 0, 0, 0);
		add_row(imm_instr(SWI, 6, 10, 5), 0, 1, 32'h114, 32'h0001_2344);
		add_row(base_instr(OR, 7, 1, 2), 0, 0, 0, 0);
		add_row(imm_instr(SWI, 7, 10, 6), 0, 1, 32'h118, 32'hffff_ffff);
		add_row(base_instr(XOR, 8, 1, 2), 0, 0, 0, 0);
		add_row(imm_instr(SWI, 8, 10, 7), 0, 1, 32'h11c, 32'hfffe_dcbb);
		add_row(imm_instr(ADDI, 9, 1, 15'h7fff), 0, 0, 0, 0);
		add_row(imm_instr(SWI, 9, 10, 8), 0, 1, 32'h120, 32'h0001_2344);
		add_row(imm_instr(ORI, 11, 1, 15'h7000), 0, 0, 0, 0);
		add_row(imm_instr(SWI, 11, 10, 9), 0, 1, 32'h124, 32'h0001_7345);
		add_row(imm_instr(XORI, 12, 2, 15'h4001), 0, 0, 0, 0);
		add_row(imm_instr(SWI, 12, 10, 10), 0, 1, 32'h128, 32'hffff_bfff);
		add_row(base_instr(SRLI, 13, 2, 4), 0, 0, 0, 0);
		add_row(imm_instr(SWI, 13, 10, 11), 0, 1, 32'h12c, 32'h0fff_ffff);
		add_row(base_instr(SLLI, 14, 1, 8), 0, 0, 0, 0);
		add_row(imm_instr(SWI, 14, 10, 12), 0, 1, 32'h130, 32'h0123_4500);
		add_row(base_instr(ROTRI, 15, 1, 4), 0, 0, 0, 0);
		add_row(imm_instr(SWI, 15, 10, 13), 0, 1, 32'h134, 32'h5000_1234);
		// loads from the preloaded low words
		add_row(movi_instr(17, 20'h00020), 0, 0, 0, 0);
		add_row(imm_instr(LWI, 16, 17, 3), 1, 0, 32'h02c, 0);
		add_row(imm_instr(SWI, 16, 10, 14), 0, 1, 32'h138, 32'h5a5a_0bf4);
		add_row(movi_instr(19, 20'h00003), 0, 0, 0, 0);
		add_row(ls_instr(LW, 18, 17, 19, 3), 1, 0, 32'h038, 0);
		add_row(imm_instr(SWI, 18, 10, 15), 0, 1, 32'h13c, 32'h5a5a_0ef1);
		add_row(ls_instr(SW, 18, 10, 19, 3), 0, 1, 32'h118, 32'h5a5a_0ef1);
		// undefined encodings leave r1, r2 and r3 alone
		add_row({1'b0, 6'h3f, 5'd1, 5'd2, 15'd0}, 0, 0, 0, 0);
		add_row(imm_instr(SWI, 1, 10, 16), 0, 1, 32'h140, 32'h0001_2345);
		add_row(base_instr(base_sub_t'(5'h1f), 2, 1, 1), 0, 0, 0, 0);
		add_row(imm_instr(SWI, 2, 10, 17), 0, 1, 32'h144, 32'hffff_fffe);
		add_row(ls_instr(ls_sub_t'(8'hff), 3, 1, 1, 0), 0, 0, 0, 0);
		add_row(imm_instr(SWI, 3, 10, 18), 0, 1, 32'h148, 32'h0001_2343);
	endtask

	task automatic run_row(input int r);
		int   waits;
		logic seen_rd;
		logic seen_wr;
		waits   = 0;
		seen_rd = 1'b0;
		seen_wr = 1'b0;
		while (im_enable !== 1'b1) begin
			@(posedge clock);
			#1;
			waits++;
			if (waits > 8) begin
				$display("timeout: im_enable never rose for instruction %0d", r);
				$display("Finished with errors");
				$fatal(1);
			end
		end
		check_value(waits, (r == 0) ? 0 : 1, "fetch spacing");
		check_value(im_addr, r * `CPU_PC_STEP, "im_addr");
		im_rdata = prog[r].instr;
		// reg_read, execute, memory, writeback
		repeat (4) begin
			@(posedge clock);
			#1;
			check_value(im_enable, 1'b0, "im_enable between fetches");
			if (dm_read) begin
				seen_rd = 1'b1;
				check_value(dm_addr, prog[r].exp_addr, "load address");
				dm_rdata = data_mem[dm_addr[8:2]];
			end
			if (dm_write) begin
				seen_wr = 1'b1;
				check_value(dm_addr, prog[r].exp_addr, "store address");
				check_value(dm_wdata, prog[r].exp_data, "store data");
				data_mem[dm_addr[8:2]] = dm_wdata;
			end
		end
		check_value(seen_rd, prog[r].exp_read, "dm_read occurrence");
		check_value(seen_wr, prog[r].exp_write, "dm_write occurrence");
	endtask

	initial begin
		reset    = 1'b1;
		im_rdata = '0;
		dm_rdata = '0;
		n_rows   = 0;
		for (int i = 0; i < 128; i++) begin
			data_mem[i] = {16'h5a5a, i[7:0], ~i[7:0]};
		end
		load_program();
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;
		for (int r = 0; r < n_rows; r++) begin
			run_row(r);
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* cpu_core_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_core_sva (
	input logic clock,
	input logic reset,
	input logic im_enable,
	input logic dm_read,
	input logic dm_write
);

	// at most one data strobe at a time
	a_dm_exclusive: assert property (@(posedge clock) disable iff (reset)
		!(dm_read && dm_write))
		else $error("dm_read and dm_write high in the same cycle");

	// one fetch every five cycles
	a_fetch_cadence: assert property (@(posedge clock) disable iff (reset)
		im_enable |=> !im_enable [*4] ##1 im_enable)
		else $error("im_enable not followed by exactly four idle cycles");

	// memory state sits three cycles after fetch
	a_dm_slot: assert property (@(posedge clock) disable iff (reset)
		(dm_read || dm_write) |-> $past(im_enable, 3))
		else $error("data strobe outside the memory state");

endmodule

bind cpu_core cpu_core_sva u_sva (
	.clock     (clock),
	.reset     (reset),
	.im_enable (im_enable),
	.dm_read   (dm_read),
	.dm_write  (dm_write)
);

`default_nettype wire

/* cpu_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module cpu_core (
	input  logic           clock,
	input  logic           reset,
	output logic           im_enable,
	output cpu_pkg::addr_t im_addr,
	input  cpu_pkg::word_t im_rdata,
	output logic           dm_read,
	output logic           dm_write,
	output cpu_pkg::addr_t dm_addr,
	output cpu_pkg::word_t dm_wdata,
	input  cpu_pkg::word_t dm_rdata
);
	import cpu_pkg::*;

	ctrl_t    ctrl;
	logic     pc_enable;
	logic     ir_load;
	logic     reg_read;
	logic     execute;
	logic     mem_phase;
	logic     reg_write;
	addr_t    pc;
	word_t    ir;
	reg_idx_t rt;
	reg_idx_t ra;
	reg_idx_t rb;
	reg_idx_t rb_idx;
	logic [4:0]  imm5;
	logic [14:0] imm15;
	logic [19:0] imm20;
	logic [1:0]  sv;
	word_t    imm15_ext;
	word_t    rd_a;
	word_t    rd_b;
	word_t    op_a_q;
	word_t    op_b_q;
	word_t    store_q;
	word_t    alu_b;
	word_t    alu_y;
	word_t    alu_q;
	word_t    load_q;
	word_t    wb_data;

	assign rt    = ir[24:20];
	assign ra    = ir[19:15];
	assign rb    = ir[14:10];
	assign imm5  = ir[14:10];
	assign imm15 = ir[14:0];
	assign imm20 = ir[19:0];
	assign sv    = ir[9:8];

	// port b fetches the store source while executing
	assign rb_idx = execute ? rt : rb;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
			ir <= '0;
		end else begin
			if (pc_enable) begin
				pc <= pc + `CPU_PC_STEP;
			end
			if (ir_load) begin
				ir <= im_rdata;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reg_read) begin
			op_a_q <= rd_a;
			op_b_q <= rd_b;
		end
		if (execute) begin
			alu_q   <= alu_y;
			store_q <= rd_b;
		end
		if (mem_phase) begin
			load_q <= dm_rdata;
		end
	end

	assign imm15_ext = {{(`CPU_XLEN-15){ctrl.imm_sign & imm15[14]}}, imm15};

	always_comb begin
		case (ctrl.opb_sel)
			opb_reg: alu_b = op_b_q;
			opb_imm5: alu_b = word_t'(imm5);
			// LWI and SWI take a word offset
			opb_imm15: alu_b = (ctrl.mem_read || ctrl.mem_write) ? imm15_ext << 2 : imm15_ext;
			default: alu_b = op_b_q << sv;
		endcase
	end

	always_comb begin
		case (ctrl.wb_sel)
			wb_imm20: wb_data = {{(`CPU_XLEN-20){imm20[19]}}, imm20};
			wb_load: wb_data = load_q;
			default: wb_data = alu_q;
		endcase
	end

	assign im_addr  = pc;
	assign dm_addr  = alu_q;
	assign dm_wdata = store_q;

	cpu_controller u_controller (
		.clock     (clock),
		.reset     (reset),
		.instr     (ir),
		.ctrl      (ctrl),
		.pc_enable (pc_enable),
		.ir_load   (ir_load),
		.reg_read  (reg_read),
		.execute   (execute),
		.mem_phase (mem_phase),
		.writeback (),
		.im_enable (im_enable),
		.dm_read   (dm_read),
		.dm_write  (dm_write),
		.reg_write (reg_write)
	);

	cpu_regfile u_regfile (
		.clock       (clock),
		.reset       (reset),
		.read_idx_a  (ra),
		.read_idx_b  (rb_idx),
		.write_idx   (rt),
		.write_en    (reg_write),
		.write_data  (wb_data),
		.read_data_a (rd_a),
		.read_data_b (rd_b)
	);

	cpu_alu u_alu (
		.op        (ctrl.alu_op),
		.operand_a (op_a_q),
		.operand_b (alu_b),
		.result    (alu_y)
	);

endmodule

`default_nettype wire

/* cpu_alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module cpu_alu (
	input  cpu_pkg::alu_op_t op,
	input  cpu_pkg::word_t   operand_a,
	input  cpu_pkg::word_t   operand_b,
	output cpu_pkg::word_t   result
);
	import cpu_pkg::*;

	localparam int SHAMT_W = $clog2(`CPU_XLEN);

	logic [SHAMT_W-1:0]    shamt;
	logic [2*`CPU_XLEN-1:0] rot;

	assign shamt = operand_b[SHAMT_W-1:0];

	// rotate through a doubled copy
	assign rot = {operand_a, operand_a} >> shamt;

	always_comb begin
		case (op)
			alu_add: result = operand_a + operand_b;
			alu_sub: result = operand_a - operand_b;
			alu_and: result = operand_a & operand_b;
			alu_or: result = operand_a | operand_b;
			alu_xor: result = operand_a ^ operand_b;
			alu_srl: result = operand_a >> shamt;
			alu_sll: result = operand_a << shamt;
			default: result = rot[`CPU_XLEN-1:0];
		endcase
	end

endmodule

`default_nettype wire

/* cpu_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "cpu_settings.svh"

module cpu_regfile (
	input  logic              clock,
	input  logic              reset,
	input  cpu_pkg::reg_idx_t read_idx_a,
	input  cpu_pkg::reg_idx_t read_idx_b,
	input  cpu_pkg::reg_idx_t write_idx,
	input  logic              write_en,
	input  cpu_pkg::word_t    write_data,
	output cpu_pkg::word_t    read_data_a,
	output cpu_pkg::word_t    read_data_b
);
	import cpu_pkg::*;

	word_t regs [`CPU_NREGS];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < `CPU_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[write_idx] <= write_data;
		end
	end

	// r0 is not hardwired
	assign read_data_a = regs[read_idx_a];
	assign read_data_b = regs[read_idx_b];

endmodule

`default_nettype wire

/* cpu_controller.sv */
`timescale 1ns/1ns
`default_nettype none

module cpu_controller (
	input  logic           clock,
	input  logic           reset,
	input  cpu_pkg::word_t instr,
	output cpu_pkg::ctrl_t ctrl,
	output logic           pc_enable,
	output logic           ir_load,
	output logic           reg_read,
	output logic           execute,
	output logic           mem_phase,
	output logic           writeback,
	output logic           im_enable,
	output logic           dm_read,
	output logic           dm_write,
	output logic           reg_write
);
	import cpu_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;
	opcode_t     opcode;
	base_sub_t   base_sub;
	ls_sub_t     ls_sub;

	assign opcode   = opcode_t'(instr[30:25]);
	assign base_sub = base_sub_t'(instr[4:0]);
	assign ls_sub   = ls_sub_t'(instr[7:0]);

	// unknown encodings fall through as a no-op
	always_comb begin
		ctrl = '{
			alu_op:    alu_add,
			opb_sel:   opb_reg,
			imm_sign:  1'b0,
			wb_sel:    wb_alu,
			mem_read:  1'b0,
			mem_write: 1'b0,
			reg_write: 1'b0
		};
		case (opcode)
			TY_BASE: begin
				ctrl.reg_write = 1'b1;
				case (base_sub)
					ADD: ctrl.alu_op = alu_add;
					SUB: ctrl.alu_op = alu_sub;
					AND: ctrl.alu_op = alu_and;
					OR: ctrl.alu_op = alu_or;
					XOR: ctrl.alu_op = alu_xor;
					SRLI: begin
						ctrl.alu_op  = alu_srl;
						ctrl.opb_sel = opb_imm5;
					end
					SLLI: begin
						ctrl.alu_op  = alu_sll;
						ctrl.opb_sel = opb_imm5;
					end
					ROTRI: begin
						ctrl.alu_op  = alu_rotr;
						ctrl.opb_sel = opb_imm5;
					end
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			ADDI: begin
				ctrl.opb_sel   = opb_imm15;
				ctrl.imm_sign  = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			ORI: begin
				ctrl.alu_op    = alu_or;
				ctrl.opb_sel   = opb_imm15;
				ctrl.reg_write = 1'b1;
			end
			XORI: begin
				ctrl.alu_op    = alu_xor;
				ctrl.opb_sel   = opb_imm15;
				ctrl.reg_write = 1'b1;
			end
			MOVI: begin
				ctrl.wb_sel    = wb_imm20;
				ctrl.reg_write = 1'b1;
			end
			// word offset scaled by 4 in the core
			LWI: begin
				ctrl.opb_sel   = opb_imm15;
				ctrl.wb_sel    = wb_load;
				ctrl.mem_read  = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			SWI: begin
				ctrl.opb_sel   = opb_imm15;
				ctrl.mem_write = 1'b1;
			end
			TY_LS: begin
				ctrl.opb_sel = opb_index;
				case (ls_sub)
					LW: begin
						ctrl.wb_sel    = wb_load;
						ctrl.mem_read  = 1'b1;
						ctrl.reg_write = 1'b1;
					end
					SW: ctrl.mem_write = 1'b1;
					default: ctrl.opb_sel = opb_reg;
				endcase
			end
			default: ctrl.reg_write = 1'b0;
		endcase
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= st_fetch;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		case (state)
			st_fetch: next_state = st_reg_read;
			st_reg_read: next_state = st_execute;
			st_execute: next_state = st_memory;
			st_memory: next_state = st_writeback;
			default: next_state = st_fetch;
		endcase
	end

	assign pc_enable = (state == st_fetch);
	assign ir_load   = (state == st_fetch);
	assign im_enable = (state == st_fetch);
	assign reg_read  = (state == st_reg_read);
	assign execute   = (state == st_execute);
	assign mem_phase = (state == st_memory);
	assign writeback = (state == st_writeback);

	// intents qualified by their phase
	assign dm_read   = ctrl.mem_read && mem_phase;
	assign dm_write  = ctrl.mem_write && mem_phase;
	assign reg_write = ctrl.reg_write && writeback;

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

	typedef logic [`CPU_XLEN-1:0] word_t;
	typedef logic [`CPU_XLEN-1:0] addr_t;
	typedef logic [`CPU_RIDX_W-1:0] reg_idx_t;

	// major opcode in instr[30:25]
	typedef enum logic [5:0] {
		TY_BASE = 6'b100000,
		ADDI    = 6'b101000,
		ORI     = 6'b101100,
		XORI    = 6'b101011,
		MOVI    = 6'b100010,
		LWI     = 6'b000010,
		SWI     = 6'b001010,
		TY_LS   = 6'b011100
	} opcode_t;

	// sub-opcode of TY_BASE in instr[4:0]
	typedef enum logic [4:0] {
		ADD   = 5'b00000,
		SUB   = 5'b00001,
		AND   = 5'b00010,
		XOR   = 5'b00011,
		OR    = 5'b00100,
		SLLI  = 5'b01000,
		SRLI  = 5'b01001,
		ROTRI = 5'b01011
	} base_sub_t;

	// sub-opcode of TY_LS in instr[7:0]
	typedef enum logic [7:0] {
		LW = 8'b00000010,
		SW = 8'b00001010
	} ls_sub_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_srl,
		alu_sll,
		alu_rotr
	} alu_op_t;

	typedef enum logic [2:0] {
		st_fetch,
		st_reg_read,
		st_execute,
		st_memory,
		st_writeback
	} ctrl_state_t;

	typedef enum logic [1:0] {
		opb_reg,
		opb_imm5,
		opb_imm15,
		opb_index
	} opb_sel_t;

	typedef enum logic [1:0] {
		wb_alu,
		wb_imm20,
		wb_load
	} wb_sel_t;

	typedef struct packed {
		alu_op_t  alu_op;
		opb_sel_t opb_sel;
		logic     imm_sign;
		wb_sel_t  wb_sel;
		logic     mem_read;
		logic     mem_write;
		logic     reg_write;
	} ctrl_t;

endpackage

`default_nettype wire

/* cpu_settings.svh */
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// data path and byte address width
`define CPU_XLEN 32

// architectural register count
`define CPU_NREGS 32

// bits needed to name one register
`define CPU_RIDX_W 5

// bytes per instruction
`define CPU_PC_STEP 4

`endif
